//--- hdl/stream_pkg.sv
// Shared definitions for the stream command processor
// Opcode encoding, field widths and the two pipeline payload structs
// Referenced by scoped name from the RTL and the testbench

package stream_pkg;

  // Operation select, all four codes defined
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,  // a + b, carry kept in bit 12
    OP_SUB = 2'd1,  // a - b mod 2^13
    OP_XOR = 2'd2,
    OP_MAX = 2'd3   // unsigned max
  } opcode_e;

  localparam int TAG_BITS  = 6;
  localparam int OPND_BITS = 12;
  localparam int RES_BITS  = 13;   // One bit wider than an operand
  localparam int SEQ_BITS  = 8;

  // Decoded command, field order mirrors the input word
  // [31:30] opcode  [29:24] tag  [23:12] a  [11:0] b
  typedef struct packed {
    opcode_e                opcode;
    logic [TAG_BITS-1:0]    tag;
    logic [OPND_BITS-1:0]   opnd_a;
    logic [OPND_BITS-1:0]   opnd_b;
  } cmd_t;   // 32 bits

  // Execution result handed to the output stage
  typedef struct packed {
    opcode_e                opcode;
    logic [TAG_BITS-1:0]    tag;
    logic [RES_BITS-1:0]    result;
  } res_t;   // 21 bits

  // Output word layout
  //   [31:26] tag  [25:24] opcode  [23:16] sequence
  //   [15:13] zero [12:0]  result

endpackage

//--- hdl/axis_reg_slice.sv
// Full-throughput valid/ready register slice with a skid register
// Input ready comes straight from a flop and the output is registered
// Payload type set by the instantiating module

module axis_reg_slice #(
  parameter type payload_t = logic [31:0]
) (
  input  logic      aclk,
  input  logic      rst_n,

  input  logic      s_axis_tvalid,
  output logic      s_axis_tready,
  input  payload_t  s_axis_tdata,

  output logic      m_axis_tvalid,
  input  logic      m_axis_tready,
  output payload_t  m_axis_tdata
);

  payload_t main_data;    // Word presented downstream
  payload_t skid_data;    // Catches the word in flight when main stalls
  logic     main_valid;
  logic     skid_valid;

  logic     in_xfer;
  logic     main_load;    // Main register free to take a new word
  logic     skid_wr;

  assign in_xfer   = s_axis_tvalid && s_axis_tready;
  assign main_load = !main_valid || m_axis_tready;
  assign skid_wr   = in_xfer && !main_load;  // Accepted but nowhere else to go

  assign s_axis_tready = !skid_valid;   // Registered ready
  assign m_axis_tvalid = main_valid;
  assign m_axis_tdata  = main_data;

  // Occupancy flags
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (main_load) begin
        main_valid <= skid_valid || in_xfer;  // Skid has priority since input is blocked then
        skid_valid <= 1'b0;
      end else if (skid_wr) begin
        skid_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (main_load) begin
      main_data <= skid_valid ? skid_data : s_axis_tdata;
    end
    if (skid_wr) begin
      skid_data <= s_axis_tdata;
    end
  end

  // Stalled output must hold its word
  a_hold_data: assert property (@(posedge aclk) disable iff (!rst_n)
    m_axis_tvalid && !m_axis_tready |=> $stable(m_axis_tdata));

  // Full skid keeps its word until main takes it
  a_skid_free: assert property (@(posedge aclk) disable iff (!rst_n)
    skid_valid && !main_load |=> skid_valid && $stable(skid_data));

endmodule

//--- hdl/axis_reg_array.sv
// Chain of N_STAGES register slices for any payload type
// Adds N_STAGES cycles of latency, keeps one word per cycle
// Holds up to 2*N_STAGES words under back-pressure

module axis_reg_array #(
  parameter int  N_STAGES  = 2,
  parameter type payload_t = logic [31:0]
) (
  input  logic      aclk,
  input  logic      rst_n,

  input  logic      s_axis_tvalid,
  output logic      s_axis_tready,
  input  payload_t  s_axis_tdata,

  output logic      m_axis_tvalid,
  input  logic      m_axis_tready,
  output payload_t  m_axis_tdata
);

  // Link i sits between slice i-1 and slice i
  logic [N_STAGES:0] valid_s;
  logic [N_STAGES:0] ready_s;
  payload_t          data_s [N_STAGES+1];

  assign valid_s[0]    = s_axis_tvalid;
  assign data_s[0]     = s_axis_tdata;
  assign s_axis_tready = ready_s[0];

  assign m_axis_tvalid     = valid_s[N_STAGES];
  assign m_axis_tdata      = data_s[N_STAGES];
  assign ready_s[N_STAGES] = m_axis_tready;

  for (genvar i = 0; i < N_STAGES; i++) begin : g_slice
    axis_reg_slice #(.payload_t(payload_t)) u_slice (
      .aclk          (aclk),
      .rst_n         (rst_n),
      .s_axis_tvalid (valid_s[i]),
      .s_axis_tready (ready_s[i]),
      .s_axis_tdata  (data_s[i]),
      .m_axis_tvalid (valid_s[i+1]),
      .m_axis_tready (ready_s[i+1]),
      .m_axis_tdata  (data_s[i+1])
    );
  end

endmodule

//--- hdl/cmd_decode.sv
// Decode stage, splits a 32-bit command word into its fields
// Single-entry pipeline register, output valid one cycle after transfer

module cmd_decode (
  input  logic              aclk,
  input  logic              rst_n,

  input  logic              s_axis_tvalid,
  output logic              s_axis_tready,
  input  logic [31:0]       s_axis_tdata,

  output logic              m_axis_tvalid,
  input  logic              m_axis_tready,
  output stream_pkg::cmd_t  m_axis_tdata
);

  logic             out_valid;
  stream_pkg::cmd_t out_cmd;
  logic             in_xfer;

  // Empty or draining this cycle
  assign s_axis_tready = !out_valid || m_axis_tready;
  assign in_xfer       = s_axis_tvalid && s_axis_tready;

  assign m_axis_tvalid = out_valid;
  assign m_axis_tdata  = out_cmd;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (s_axis_tready) begin
      out_valid <= s_axis_tvalid;  // Refill or go empty
    end
  end

  // Field split per the command word layout
  always_ff @(posedge aclk) begin
    if (in_xfer) begin
      out_cmd.opcode <= stream_pkg::opcode_e'(s_axis_tdata[31:30]);
      out_cmd.tag    <= s_axis_tdata[29:24];
      out_cmd.opnd_a <= s_axis_tdata[23:12];
      out_cmd.opnd_b <= s_axis_tdata[11:0];
    end
  end

  // Upstream keeps its offer up until taken
  a_in_held: assert property (@(posedge aclk) disable iff (!rst_n)
    s_axis_tvalid && !s_axis_tready |=> s_axis_tvalid && $stable(s_axis_tdata));

endmodule

//--- hdl/alu_execute.sv
// Execute stage, computes the 13-bit result of a decoded command
// Tag and opcode travel with the result
// Single-entry pipeline register, one cycle of latency

module alu_execute (
  input  logic              aclk,
  input  logic              rst_n,

  input  logic              s_axis_tvalid,
  output logic              s_axis_tready,
  input  stream_pkg::cmd_t  s_axis_tdata,

  output logic              m_axis_tvalid,
  input  logic              m_axis_tready,
  output stream_pkg::res_t  m_axis_tdata
);

  logic                             out_valid;
  stream_pkg::res_t                 out_res;
  logic                             in_xfer;
  logic [stream_pkg::RES_BITS-1:0]  alu_out;
  logic [stream_pkg::RES_BITS-1:0]  a_ext;
  logic [stream_pkg::RES_BITS-1:0]  b_ext;

  assign s_axis_tready = !out_valid || m_axis_tready;
  assign in_xfer       = s_axis_tvalid && s_axis_tready;

  assign m_axis_tvalid = out_valid;
  assign m_axis_tdata  = out_res;

  // Zero-extend so ADD carry and SUB wrap fall out of 13-bit math
  assign a_ext = {1'b0, s_axis_tdata.opnd_a};
  assign b_ext = {1'b0, s_axis_tdata.opnd_b};

  always_comb begin
    alu_out = '0;
    case (s_axis_tdata.opcode)
      stream_pkg::OP_ADD: alu_out = a_ext + b_ext;  // Carry lands in bit 12
      stream_pkg::OP_SUB: alu_out = a_ext - b_ext;  // Mod 8192
      stream_pkg::OP_XOR: alu_out = a_ext ^ b_ext;
      stream_pkg::OP_MAX: alu_out = (a_ext > b_ext) ? a_ext : b_ext;
      default:            alu_out = '0;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (s_axis_tready) begin
      out_valid <= s_axis_tvalid;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_xfer) begin
      out_res.opcode <= s_axis_tdata.opcode;
      out_res.tag    <= s_axis_tdata.tag;
      out_res.result <= alu_out;
    end
  end

endmodule

//--- hdl/result_pack.sv
// Output stage, packs a result with a running sequence number
// Word layout: tag, opcode, sequence, three zero bits, result
// Sequence stamps each accepted result and wraps at 256

module result_pack (
  input  logic              aclk,
  input  logic              rst_n,

  input  logic              s_axis_tvalid,
  output logic              s_axis_tready,
  input  stream_pkg::res_t  s_axis_tdata,

  output logic              m_axis_tvalid,
  input  logic              m_axis_tready,
  output logic [31:0]       m_axis_tdata
);

  logic                             out_valid;
  logic [31:0]                      out_word;
  logic                             in_xfer;
  logic [stream_pkg::SEQ_BITS-1:0]  seq_q;   // Number for the next accepted result

  assign s_axis_tready = !out_valid || m_axis_tready;
  assign in_xfer       = s_axis_tvalid && s_axis_tready;

  assign m_axis_tvalid = out_valid;
  assign m_axis_tdata  = out_word;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      seq_q     <= '0;
    end else begin
      if (s_axis_tready) begin
        out_valid <= s_axis_tvalid;
      end
      if (in_xfer) begin
        seq_q <= seq_q + 1'b1;  // Natural wrap 255 -> 0
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (in_xfer) begin
      out_word <= {s_axis_tdata.tag, s_axis_tdata.opcode, seq_q,
                   3'b000, s_axis_tdata.result};
    end
  end

  // Counter moves only with an accepted result
  a_seq_step: assert property (@(posedge aclk) disable iff (!rst_n)
    !in_xfer |=> $stable(seq_q));

endmodule

//--- hdl/stream_alu_top.sv
// Top level of the stream command processor
// decode -> register array -> execute -> register array -> pack
// Latency 3 + 2*N_STAGES cycles, one word per cycle sustained

module stream_alu_top #(
  parameter int N_STAGES = 2
) (
  input  logic        aclk,
  input  logic        rst_n,

  input  logic        s_axis_tvalid,
  output logic        s_axis_tready,
  input  logic [31:0] s_axis_tdata,

  output logic        m_axis_tvalid,
  input  logic        m_axis_tready,
  output logic [31:0] m_axis_tdata
);

  // Decoded command links
  logic             dec_valid, dec_ready;
  stream_pkg::cmd_t dec_data;
  logic             cmd_valid, cmd_ready;
  stream_pkg::cmd_t cmd_data;

  // Result links
  logic             exe_valid, exe_ready;
  stream_pkg::res_t exe_data;
  logic             res_valid, res_ready;
  stream_pkg::res_t res_data;

  cmd_decode u_decode (
    .aclk (aclk), .rst_n (rst_n),
    .s_axis_tvalid (s_axis_tvalid), .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .m_axis_tvalid (dec_valid), .m_axis_tready (dec_ready), .m_axis_tdata (dec_data)
  );

  axis_reg_array #(.N_STAGES(N_STAGES), .payload_t(stream_pkg::cmd_t)) u_reg_cmd (
    .aclk (aclk), .rst_n (rst_n),
    .s_axis_tvalid (dec_valid), .s_axis_tready (dec_ready), .s_axis_tdata (dec_data),
    .m_axis_tvalid (cmd_valid), .m_axis_tready (cmd_ready), .m_axis_tdata (cmd_data)
  );

  alu_execute u_execute (
    .aclk (aclk), .rst_n (rst_n),
    .s_axis_tvalid (cmd_valid), .s_axis_tready (cmd_ready), .s_axis_tdata (cmd_data),
    .m_axis_tvalid (exe_valid), .m_axis_tready (exe_ready), .m_axis_tdata (exe_data)
  );

  axis_reg_array #(.N_STAGES(N_STAGES), .payload_t(stream_pkg::res_t)) u_reg_res (
    .aclk (aclk), .rst_n (rst_n),
    .s_axis_tvalid (exe_valid), .s_axis_tready (exe_ready), .s_axis_tdata (exe_data),
    .m_axis_tvalid (res_valid), .m_axis_tready (res_ready), .m_axis_tdata (res_data)
  );

  result_pack u_pack (
    .aclk (aclk), .rst_n (rst_n),
    .s_axis_tvalid (res_valid), .s_axis_tready (res_ready), .s_axis_tdata (res_data),
    .m_axis_tvalid (m_axis_tvalid), .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata)
  );

endmodule

//--- tb/tb_clkgen.sv
// Testbench clock and power-on reset
// Clock period PERIOD, rst_n held low for RST_CYCLES rising edges

module tb_clkgen #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 3
) (
  output logic aclk,
  output logic rst_n
);

  initial begin
    aclk = 1'b0;
    forever #(PERIOD / 2) aclk = ~aclk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge aclk);
    rst_n <= 1'b1;  // Released on an edge like any other input
  end

endmodule

//--- tb/tb_top.sv
// Testbench for the stream command processor
// Pushes commands, keeps a FIFO of expected output words from a reference model,
// and lets concurrent assertions compare every output transfer against it

module tb_top;

  localparam int          N_STAGES  = 2;
  localparam int          TMO       = 200;           // Cycle limit of every wait
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic        aclk, por_n, soft_rst_n, dut_rst_n;
  logic        s_axis_tvalid, s_axis_tready;
  logic [31:0] s_axis_tdata;
  logic        m_axis_tvalid, m_axis_tready;
  logic [31:0] m_axis_tdata;

  logic [31:0] exp_mem [1024];   // Expected words in push order
  logic [9:0]  wr_ptr, rd_ptr, pending;
  logic [31:0] exp_head;
  logic [7:0]  tb_seq;           // Next sequence number to expect
  logic [31:0] lfsr;
  logic        rand_ready;       // m_axis_tready from LFSR bits
  int          err_data, err_rst, err_spur, err_flow;
  int          err_mark, n_tests, n_failed;

  tb_clkgen #(.PERIOD(4), .RST_CYCLES(3)) u_clkgen (.aclk(aclk), .rst_n(por_n));

  assign dut_rst_n = por_n && soft_rst_n;
  assign exp_head  = exp_mem[rd_ptr];
  assign pending   = wr_ptr - rd_ptr;

  stream_alu_top #(.N_STAGES(N_STAGES)) u_dut (
    .aclk (aclk), .rst_n (dut_rst_n),
    .s_axis_tvalid (s_axis_tvalid), .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid), .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata)
  );

  // Reference model of one command in integer math
  function automatic logic [31:0] expect_word(input logic [31:0] cmd, input logic [7:0] seq);
    int a;
    int b;
    int r;
    a = {20'd0, cmd[23:12]};
    b = {20'd0, cmd[11:0]};
    case (cmd[31:30])
      stream_pkg::OP_ADD: r = a + b;                   // Up to 8190 with carry in bit 12
      stream_pkg::OP_SUB: r = (a - b + 8192) % 8192;
      stream_pkg::OP_XOR: r = a ^ b;
      default:            r = (a > b) ? a : b;         // MAX
    endcase
    return {cmd[29:24], cmd[31:30], seq, 3'b000, r[12:0]};
  endfunction

  // Galois LFSR stepped once per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic int total_errors();
    return err_data + err_rst + err_spur + err_flow;
  endfunction

  // One expected word per accepted command
  always @(posedge aclk) begin
    if (!dut_rst_n) begin
      wr_ptr <= '0;
      tb_seq <= '0;
    end else if (s_axis_tvalid && s_axis_tready) begin
      exp_mem[wr_ptr] <= expect_word(s_axis_tdata, tb_seq);
      wr_ptr          <= wr_ptr + 10'd1;
      tb_seq          <= tb_seq + 8'd1;  // Wraps with the DUT counter
    end
  end

  // Output side pops the head
  always @(posedge aclk) begin
    if (!dut_rst_n) begin
      rd_ptr <= '0;
    end else if (m_axis_tvalid && m_axis_tready) begin
      rd_ptr <= rd_ptr + 10'd1;
    end
  end

  chk_data: assert property (@(posedge aclk) disable iff (!dut_rst_n)
    m_axis_tvalid && m_axis_tready |-> m_axis_tdata == exp_head)
    else begin
      $display("[ERROR] m_axis_tdata got %08h expected %08h",
               $sampled(m_axis_tdata), $sampled(exp_head));
      err_data++;
    end

  // First cycle out of reset
  chk_rst: assert property (@(posedge aclk) $rose(dut_rst_n) |-> !m_axis_tvalid)
    else begin
      $display("[ERROR] m_axis_tvalid got %0h expected %0h", 1'b1, 1'b0);
      err_rst++;
    end

  chk_spur: assert property (@(posedge aclk) disable iff (!dut_rst_n)
    m_axis_tvalid |-> pending != 10'd0)
    else begin
      $display("output word appeared with no command in flight");
      err_spur++;
    end

  task automatic next_cycle();
    logic [31:0] r;
    @(posedge aclk);
    if (rand_ready) begin
      r = rand_bits(1);
      m_axis_tready <= r[0];
    end
  endtask

  task automatic idle(input int n);
    for (int k = 0; k < n; k++) next_cycle();
  endtask

  // Hold the current offer until it is taken
  task automatic wait_accept();
    int n;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (!s_axis_tready && n < TMO);
    if (!s_axis_tready) begin
      $display("timeout: command never accepted");
      err_flow++;
    end
    s_axis_tvalid <= 1'b0;
  endtask

  task automatic send_cmd(input logic [31:0] word);
    s_axis_tvalid <= 1'b1;
    s_axis_tdata  <= word;
    wait_accept();
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pending != 10'd0 && n < TMO) begin
      next_cycle();
      n++;
    end
    if (pending != 10'd0) begin
      $display("timeout: %0d words never came out", pending);
      err_flow++;
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (dut_rst_n !== 1'b1 && n < 20) begin
      next_cycle();
      n++;
    end
    if (dut_rst_n !== 1'b1) begin
      $display("timeout: reset never released");
      err_flow++;
    end
  endtask

  // Offer words with ready held low until the input stalls
  task automatic fill_until_stall(output int accepted);
    logic [31:0] r;
    int n;
    accepted = 0;
    n        = 0;
    r        = rand_bits(32);
    s_axis_tvalid <= 1'b1;
    s_axis_tdata  <= r;
    while (n < 40) begin
      next_cycle();
      n++;
      if (!s_axis_tready) break;
      accepted++;
      r = rand_bits(32);
      s_axis_tdata <= r;
    end
    if (s_axis_tready) begin
      $display("s_axis_tready never dropped with the output stalled");
      err_flow++;
    end
  endtask

  task automatic test_done(input string name);
    int now;
    now = total_errors();
    n_tests++;
    if (now == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      n_failed++;
      $display("test %s: failed with %0d errors", name, now - err_mark);
    end
    err_mark = now;
  endtask

  initial begin
    logic [31:0] r;
    int acc;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    m_axis_tready = 1'b1;
    soft_rst_n    = 1'b1;
    rand_ready    = 1'b0;
    lfsr          = 32'hace59bc5;
    err_data      = 0;
    err_rst       = 0;
    err_spur      = 0;
    err_flow      = 0;
    err_mark      = 0;
    n_tests       = 0;
    n_failed      = 0;

    wait_reset_release();
    idle(12);                                      // Nothing may come out
    test_done("reset_state");

    send_cmd({stream_pkg::OP_ADD, 6'h2a, 12'hfff, 12'h001});  // Carry only
    send_cmd({stream_pkg::OP_ADD, 6'h15, 12'h800, 12'h900});
    send_cmd({stream_pkg::OP_ADD, 6'h3f, 12'hfff, 12'hfff});  // Max sum
    for (int i = 0; i < 10; i++) begin
      r = rand_bits(30);
      send_cmd({stream_pkg::OP_ADD, r[29:0]});
    end
    wait_drain();
    test_done("add_carry");

    send_cmd({stream_pkg::OP_SUB, 6'h01, 12'h005, 12'h010});  // Wraps to 1ff5
    send_cmd({stream_pkg::OP_SUB, 6'h02, 12'h000, 12'hfff});
    for (int i = 0; i < 10; i++) begin
      r = rand_bits(30);
      send_cmd({stream_pkg::OP_SUB, r[29:0]});
    end
    wait_drain();
    test_done("sub_wrap");

    for (int i = 0; i < 20; i++) begin
      r = rand_bits(30);
      send_cmd({stream_pkg::OP_XOR, r[29:0]});
      r = rand_bits(30);
      send_cmd({stream_pkg::OP_MAX, r[29:0]});
    end
    wait_drain();
    test_done("xor_max");

    rand_ready = 1'b1;
    for (int i = 0; i < 300; i++) begin
      r = rand_bits(32);
      send_cmd(r);
    end
    rand_ready = 1'b0;
    m_axis_tready <= 1'b1;
    wait_drain();
    m_axis_tready <= 1'b0;
    fill_until_stall(acc);
    if (acc != 3 + 4 * N_STAGES) begin
      $display("[ERROR] accepted_words got %0h expected %0h", acc, 3 + 4 * N_STAGES);
      err_flow++;
    end
    m_axis_tready <= 1'b1;
    wait_accept();                                 // Word left on the input
    wait_drain();
    test_done("back_pressure");

    for (int i = 0; i < 260; i++) begin            // Back-to-back so seq wraps again
      r = rand_bits(32);
      send_cmd(r);
    end
    wait_drain();
    soft_rst_n <= 1'b0;                            // Pipeline empty here
    idle(3);
    soft_rst_n <= 1'b1;
    wait_reset_release();
    idle(8);
    send_cmd({stream_pkg::OP_XOR, 6'h11, 12'habc, 12'h123});  // Expect seq 0
    send_cmd({stream_pkg::OP_MAX, 6'h12, 12'h004, 12'h400});
    wait_drain();
    test_done("sequence");

    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total_errors());
    if (n_failed == 0 && total_errors() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
hdl/stream_pkg.sv
hdl/axis_reg_slice.sv
hdl/axis_reg_array.sv
hdl/cmd_decode.sv
hdl/alu_execute.sv
hdl/result_pack.sv
hdl/stream_alu_top.sv
tb/tb_clkgen.sv
tb/tb_top.sv

//--- Makefile
# Verilator flow for the stream command processor
# make lint | make sim | make clean

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the run output
sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
